// File: logic/prbsPkg.sv
//------------------------------------------------
// Shared types and constants for the PRBS link
// test subsystem. Imported by every lane module.
//------------------------------------------------

package prbsPkg;

  //------------------------------------------------
  // Word and count widths
  //------------------------------------------------
  localparam int dataWidth = 64;
  // Enough bits to count 0 to dataWidth differing bits
  localparam int bitErrsWidth = $clog2(dataWidth + 1);
  localparam int errCountWidth = 32;

  typedef logic [dataWidth-1:0] word_t;
  typedef logic [bitErrsWidth-1:0] bitErrs_t;
  typedef logic [errCountWidth-1:0] errCount_t;

  //------------------------------------------------
  // Link constants
  //------------------------------------------------
  // Lower 64 bits of the 80-bit lane alignment pattern
  localparam word_t alignWord = 64'h92B4_AE2E_4AD2_B87C;
  // Idle value, nonzero so the PRBS never locks up
  localparam word_t prbsInitVal = word_t'(97);
  // Alignment words in a row before rxAlign
  localparam int alignCount = 4;
  localparam int alignCntWidth = $clog2(alignCount + 1);

  // Feedback taps, 1-based as in x^7 + x^6 + 1
  localparam int prbs7TapA = 7;
  localparam int prbs7TapB = 6;
  localparam int prbs9TapA = 9;
  localparam int prbs9TapB = 5;
  localparam int prbs23TapA = 23;
  localparam int prbs23TapB = 18;
  localparam int prbs31TapA = 31;
  localparam int prbs31TapB = 28;

  //------------------------------------------------
  // Control, status and FSM types
  //------------------------------------------------
  typedef enum logic [1:0] {selPrbs7, selPrbs9, selPrbs23, selPrbs31} prbsSel_t;

  typedef struct packed {
    logic     enable;
    prbsSel_t sel;
    logic     errInject;
  } txCtrl_t;

  typedef struct packed {
    logic     locked;
    logic     errValid;
    bitErrs_t bitErrs;
  } chkStatus_t;

  typedef enum logic [1:0] {chkIdle, chkSeed, chkRun} chkState_t;
  typedef enum logic {rdIdle, rdHold} rdState_t;

endpackage

// File: logic/prbsGen.sv
//------------------------------------------------
// Transmit side of the lane test. Sends the
// alignment word until rxAlign, then the selected
// PRBS at 64 bits per TX_CLK, with bit 0 error
// injection on request.
//------------------------------------------------
`timescale 1ns/1ps

module prbsGen (
  input  logic             TX_CLK,
  input  logic             SYS_RESET_N,
  input  logic             txClkStable,
  input  prbsPkg::txCtrl_t txCtrl,
  input  logic             rxAlign,
  output prbsPkg::word_t   txData
);
  import prbsPkg::*;

  //------------------------------------------------
  // PRBS advance
  //------------------------------------------------
  // One full word of LFSR shifts, feedback enters at bit 0
  function automatic word_t prbsStep(word_t cur, int tapA, int tapB);
    word_t s;
    logic  fb;
    s = cur;
    for (int i = 0; i < dataWidth; i++) begin
      fb = s[tapA-1] ^ s[tapB-1];
      s = {s[dataWidth-2:0], fb};
    end
    return s;
  endfunction

  // Bit 0 of the last word was flipped
  logic  injFlag;
  // Last word without the injected error
  word_t prevClean;
  word_t next7;
  word_t next9;
  word_t next23;
  word_t next31;
  word_t nextPrbs;

  // Undo the injected flip so errors do not spread into the sequence
  assign prevClean = txData ^ word_t'(injFlag);

  // All four patterns built, sel picks one
  assign next7 = prbsStep(prevClean, prbs7TapA, prbs7TapB);
  assign next9 = prbsStep(prevClean, prbs9TapA, prbs9TapB);
  assign next23 = prbsStep(prevClean, prbs23TapA, prbs23TapB);
  assign next31 = prbsStep(prevClean, prbs31TapA, prbs31TapB);

  always_comb begin
    case (txCtrl.sel)
      selPrbs7:  nextPrbs = next7;
      selPrbs9:  nextPrbs = next9;
      selPrbs23: nextPrbs = next23;
      default:   nextPrbs = next31;
    endcase
  end

  //------------------------------------------------
  // Transmit word register
  //------------------------------------------------
  always_ff @(posedge TX_CLK or negedge SYS_RESET_N) begin
    if (!SYS_RESET_N) begin
      txData <= prbsInitVal;
      injFlag <= 1'b0;
    end else if (!txClkStable || !txCtrl.enable) begin
      // Link down, park on the idle value
      txData <= prbsInitVal;
      injFlag <= 1'b0;
    end else if (!rxAlign) begin
      // Not aligned yet
      txData <= alignWord;
      injFlag <= 1'b0;
    end else begin
      txData <= {nextPrbs[dataWidth-1:1], nextPrbs[0] ^ txCtrl.errInject};
      injFlag <= txCtrl.errInject;
    end
  end

endmodule

// File: logic/alignDetect.sv
//------------------------------------------------
// Receive alignment detector. Latches rxAlign
// after alignCount alignment words in a row and
// drops it when the idle value shows up.
//------------------------------------------------
`timescale 1ns/1ps

module alignDetect (
  input  logic           TX_CLK,
  input  logic           SYS_RESET_N,
  input  prbsPkg::word_t rxData,
  output logic           rxAlign
);
  import prbsPkg::*;

  // Consecutive alignment words seen so far
  logic [alignCntWidth-1:0] matchCnt;
  logic                     isAlign;
  logic                     isIdle;
  logic                     lastMatch;

  assign isAlign = (rxData == alignWord);
  // Idle value on the lane means transmit is disabled
  assign isIdle = (rxData == prbsInitVal);
  assign lastMatch = (matchCnt == alignCntWidth'(alignCount - 1));

  //------------------------------------------------
  // Match counter and latch
  //------------------------------------------------
  always_ff @(posedge TX_CLK or negedge SYS_RESET_N) begin
    if (!SYS_RESET_N) begin
      matchCnt <= '0;
      rxAlign <= 1'b0;
    end else if (rxAlign) begin
      // Locked, only the idle value releases it
      if (isIdle) begin
        rxAlign <= 1'b0;
        matchCnt <= '0;
      end
    end else if (isAlign) begin
      if (lastMatch) begin
        rxAlign <= 1'b1;
        matchCnt <= '0;
      end else begin
        matchCnt <= matchCnt + 1'b1;
      end
    end else begin
      // Any other word restarts the search
      matchCnt <= '0;
    end
  end

endmodule

// File: logic/prbsChecker.sv
//------------------------------------------------
// Receive PRBS checker. Seeds from the first word
// after the alignment run, then free-runs and
// reports differing bits per word, two cycles
// behind the received word.
//------------------------------------------------
`timescale 1ns/1ps

module prbsChecker (
  input  logic               TX_CLK,
  input  logic               SYS_RESET_N,
  input  prbsPkg::word_t     rxData,
  input  logic               rxAlign,
  input  prbsPkg::prbsSel_t  sel,
  output prbsPkg::chkStatus_t status
);
  import prbsPkg::*;

  //------------------------------------------------
  // Helpers
  //------------------------------------------------
  function automatic word_t prbsStep(word_t cur, int tapA, int tapB);
    word_t s;
    logic  fb;
    s = cur;
    for (int i = 0; i < dataWidth; i++) begin
      fb = s[tapA-1] ^ s[tapB-1];
      s = {s[dataWidth-2:0], fb};
    end
    return s;
  endfunction

  // Same pattern choice as the generator
  function automatic word_t prbsAdvance(word_t cur, prbsSel_t patSel);
    case (patSel)
      selPrbs7:  return prbsStep(cur, prbs7TapA, prbs7TapB);
      selPrbs9:  return prbsStep(cur, prbs9TapA, prbs9TapB);
      selPrbs23: return prbsStep(cur, prbs23TapA, prbs23TapB);
      default:   return prbsStep(cur, prbs31TapA, prbs31TapB);
    endcase
  endfunction

  function automatic bitErrs_t popCount(word_t w);
    bitErrs_t n;
    n = '0;
    for (int i = 0; i < dataWidth; i++) begin
      n = n + bitErrs_t'(w[i]);
    end
    return n;
  endfunction

  chkState_t state;
  // Expected value of the word arriving next
  word_t     predict;
  word_t     predictNext;
  word_t     advanceSrc;
  word_t     diff;
  logic      diffValid;
  logic      errValid;
  bitErrs_t  bitErrs;
  logic      linkDown;
  logic      seedNow;

  // Idle value on the lane means the link has gone away
  assign linkDown = !rxAlign || (rxData == prbsInitVal);
  assign seedNow = (state == chkSeed) && !linkDown && (rxData != alignWord);

  // Seed from the stream once, free-run after that
  assign advanceSrc = (state == chkSeed) ? rxData : predict;
  assign predictNext = prbsAdvance(advanceSrc, sel);

  //------------------------------------------------
  // Lock FSM
  //------------------------------------------------
  always_ff @(posedge TX_CLK or negedge SYS_RESET_N) begin
    if (!SYS_RESET_N) begin
      state <= chkIdle;
      diffValid <= 1'b0;
      errValid <= 1'b0;
    end else begin
      case (state)
        chkIdle: if (rxAlign) state <= chkSeed;
        chkSeed: begin
          if (linkDown) state <= chkIdle;
          else if (seedNow) state <= chkRun;
        end
        default: if (linkDown) state <= chkIdle;
      endcase
      // Compare stage valid only for live words in run
      diffValid <= (state == chkRun) && !linkDown;
      errValid <= diffValid;
    end
  end

  //------------------------------------------------
  // Prediction and compare pipeline
  //------------------------------------------------
  always_ff @(posedge TX_CLK) begin
    if (seedNow || (state == chkRun)) predict <= predictNext;
    diff <= predict ^ rxData;
    bitErrs <= popCount(diff);
  end

  assign status = '{locked: (state == chkRun), errValid: errValid, bitErrs: bitErrs};

endmodule

// File: logic/errReadout.sv
//------------------------------------------------
// Error count readout. Accumulates bitErrs with
// saturation; a four-phase cntReq/cntAck read
// snapshots the count into errCount and clears it.
//------------------------------------------------
`timescale 1ns/1ps

module errReadout (
  input  logic                TX_CLK,
  input  logic                SYS_RESET_N,
  input  prbsPkg::chkStatus_t status,
  input  logic                cntReq,
  output logic                cntAck,
  output prbsPkg::errCount_t  errCount
);
  import prbsPkg::*;

  rdState_t                rdState;
  errCount_t               accum;
  errCount_t               errExt;
  logic [errCountWidth:0]  sum;
  errCount_t               accumAdd;
  logic                    snapshot;

  //------------------------------------------------
  // Saturating add
  //------------------------------------------------
  assign errExt = errCount_t'(status.bitErrs);
  assign sum = {1'b0, accum} + {1'b0, errExt};
  // Carry out means overflow, pin at all ones
  assign accumAdd = sum[errCountWidth] ? '1 : sum[errCountWidth-1:0];

  // First cycle of a new request
  assign snapshot = (rdState == rdIdle) && cntReq;
  assign cntAck = (rdState == rdHold);

  //------------------------------------------------
  // Handshake FSM and accumulator
  //------------------------------------------------
  always_ff @(posedge TX_CLK or negedge SYS_RESET_N) begin
    if (!SYS_RESET_N) begin
      rdState <= rdIdle;
      accum <= '0;
      errCount <= '0;
    end else begin
      case (rdState)
        rdIdle: if (cntReq) rdState <= rdHold;
        default: if (!cntReq) rdState <= rdIdle;
      endcase
      if (snapshot) begin
        errCount <= accum;
        // Same-cycle error opens the new accumulation
        accum <= status.errValid ? errExt : '0;
      end else if (status.errValid) begin
        accum <= accumAdd;
      end
    end
  end

endmodule

// File: logic/prbsLinkTop.sv
//------------------------------------------------
// Lane test top level. Generator output loops
// straight back into the alignment detector and
// checker; the host reads errors over cntReq/Ack.
//------------------------------------------------
`timescale 1ns/1ps

module prbsLinkTop (
  input  logic               TX_CLK,
  input  logic               SYS_RESET_N,
  input  logic               txClkStable,
  input  prbsPkg::txCtrl_t   txCtrl,
  input  logic               cntReq,
  output prbsPkg::word_t     txData,
  output logic               locked,
  output logic               cntAck,
  output prbsPkg::errCount_t errCount
);
  import prbsPkg::*;

  // Alignment feedback to generator and checker
  logic       rxAlign;
  chkStatus_t status;

  //------------------------------------------------
  // Transmit
  //------------------------------------------------
  prbsGen gen0 (
    .TX_CLK      (TX_CLK),
    .SYS_RESET_N (SYS_RESET_N),
    .txClkStable (txClkStable),
    .txCtrl      (txCtrl),
    .rxAlign     (rxAlign),
    .txData      (txData)
  );

  //------------------------------------------------
  // Receive, fed by the internal loopback
  //------------------------------------------------
  alignDetect align0 (
    .TX_CLK      (TX_CLK),
    .SYS_RESET_N (SYS_RESET_N),
    .rxData      (txData),
    .rxAlign     (rxAlign)
  );

  prbsChecker chk0 (
    .TX_CLK      (TX_CLK),
    .SYS_RESET_N (SYS_RESET_N),
    .rxData      (txData),
    .rxAlign     (rxAlign),
    .sel         (txCtrl.sel),
    .status      (status)
  );

  // Host side error readout
  errReadout rd0 (
    .TX_CLK      (TX_CLK),
    .SYS_RESET_N (SYS_RESET_N),
    .status      (status),
    .cntReq      (cntReq),
    .cntAck      (cntAck),
    .errCount    (errCount)
  );

  assign locked = status.locked;

endmodule

// File: test/tbClock.sv
//------------------------------------------------
// Testbench clock and reset. 10 ns TX_CLK, with
// SYS_RESET_N low for the first 5 cycles
//------------------------------------------------
`timescale 1ns/1ps

module tbClock (
  output logic TX_CLK,
  output logic SYS_RESET_N
);
  localparam int halfPeriodNs = 5;
  localparam int resetCycles = 5;

  initial begin
    TX_CLK = 1'b0;
    forever #(halfPeriodNs) TX_CLK = ~TX_CLK;
  end

  initial begin
    SYS_RESET_N = 1'b0;
    repeat (resetCycles) @(posedge TX_CLK);
    // Release on a falling edge, away from the sampling edge
    @(negedge TX_CLK);
    SYS_RESET_N = 1'b1;
  end

endmodule

// File: test/prbsLink_props.sv
//------------------------------------------------
// Timing and handshake checks on the lane top.
// Bound into prbsLinkTop; failures bump failCount.
//------------------------------------------------
`timescale 1ns/1ps

module prbsLink_props (
  input logic               TX_CLK,
  input logic               SYS_RESET_N,
  input logic               txClkStable,
  input prbsPkg::txCtrl_t   txCtrl,
  input logic               cntReq,
  input prbsPkg::word_t     txData,
  input logic               rxAlign,
  input logic               locked,
  input logic               cntAck,
  input prbsPkg::errCount_t errCount
);
  import prbsPkg::*;

  // Failed checks so far, polled by the testbench top
  int   failCount = 0;
  logic linkOn;
  logic sawAlign;

  assign linkOn = txClkStable && txCtrl.enable;
  assign sawAlign = (txData == alignWord);

  task automatic flagFail(input string what);
    $error("%s", what);
    failCount++;
  endtask

  //--------------------------------------------------
  // Link bring-up and lock
  //--------------------------------------------------
  alignSent: assert property (@(posedge TX_CLK) disable iff (!SYS_RESET_N)
    linkOn && !rxAlign |=> sawAlign) else flagFail("alignment word not sent");

  // rxAlign one cycle after the fourth alignment word in a row
  alignLocks: assert property (@(posedge TX_CLK) disable iff (!SYS_RESET_N)
    sawAlign && $past(sawAlign) && $past(sawAlign, 2) && $past(sawAlign, 3) && !rxAlign
    |=> rxAlign) else flagFail("rxAlign missing after four alignment words");

  noAlignLocked: assert property (@(posedge TX_CLK) disable iff (!SYS_RESET_N)
    locked |-> !sawAlign) else flagFail("alignment word sent while locked");

  //--------------------------------------------------
  // Count readout handshake
  //--------------------------------------------------
  ackRise: assert property (@(posedge TX_CLK) disable iff (!SYS_RESET_N)
    $rose(cntAck) |-> $past(cntReq)) else flagFail("cntAck rose without cntReq");

  ackFall: assert property (@(posedge TX_CLK) disable iff (!SYS_RESET_N)
    $fell(cntAck) |-> !$past(cntReq)) else flagFail("cntAck fell while cntReq high");

  // Snapshot lands on the ack edge and then holds
  countHeld: assert property (@(posedge TX_CLK) disable iff (!SYS_RESET_N)
    cntAck && $past(cntAck) |-> $stable(errCount)) else flagFail("errCount moved during ack");

  //--------------------------------------------------
  // Link shutdown
  //--------------------------------------------------
  idleOnDisable: assert property (@(posedge TX_CLK) disable iff (!SYS_RESET_N)
    !linkOn |=> txData == prbsInitVal) else flagFail("txData not idle after disable");

  lockDrops: assert property (@(posedge TX_CLK) disable iff (!SYS_RESET_N)
    $past(!linkOn, 2) |-> !locked) else flagFail("locked still high after disable");

endmodule

bind prbsLinkTop prbsLink_props props0 (.*);

// File: test/prbsLinkTb.sv
//------------------------------------------------
// Testbench top for the PRBS lane. Runs the four
// patterns with random bit 0 errors and reads the
// error count back over cntReq/cntAck.
//------------------------------------------------
`timescale 1ns/1ps

module prbsLinkTb;
  import prbsPkg::*;

  localparam int randSeed = 81565;
  localparam int clkPeriodNs = 10;
  localparam int lockedCycles = 200;
  // Extra cycles the host keeps cntReq up after cntAck
  localparam int holdCycles = 2;
  // Bring-up, injection, two reads and shutdown per pattern
  localparam int patternBudget = 300;
  localparam int marginCycles = 200;
  localparam int timeoutNs = (4 * patternBudget + marginCycles) * clkPeriodNs;

  logic      TX_CLK;
  logic      SYS_RESET_N;
  logic      txClkStable;
  txCtrl_t   txCtrl;
  logic      cntReq;
  word_t     txData;
  logic      locked;
  logic      cntAck;
  errCount_t errCount;

  tbClock clk0 (
    .TX_CLK      (TX_CLK),
    .SYS_RESET_N (SYS_RESET_N)
  );

  prbsLinkTop dut0 (
    .TX_CLK      (TX_CLK),
    .SYS_RESET_N (SYS_RESET_N),
    .txClkStable (txClkStable),
    .txCtrl      (txCtrl),
    .cntReq      (cntReq),
    .txData      (txData),
    .locked      (locked),
    .cntAck      (cntAck),
    .errCount    (errCount)
  );

  //--------------------------------------------------
  // Host side
  //--------------------------------------------------
  // Four-phase read that checks errCount while cntAck holds the snapshot
  task automatic readAndCheck(input int unsigned expected, input string what);
    cntReq = 1'b1;
    while (!cntAck) @(negedge TX_CLK);
    countMatch: assert (errCount == expected) else begin
      $display("FAIL %0t ns: %s errCount %0d, expected %0d", $time, what, errCount, expected);
      $display("RESULT: FAIL");
      $fatal(1, "error count mismatch");
    end
    // Several cycles of cntAck high with the snapshot held
    repeat (holdCycles) @(negedge TX_CLK);
    cntReq = 1'b0;
    while (cntAck) @(negedge TX_CLK);
  endtask

  // Bring up one pattern, inject, read twice, take the link down
  task automatic runPattern(input prbsSel_t sel, input bit dropClock);
    int unsigned tally;
    tally = 0;
    txCtrl.sel = sel;
    txCtrl.enable = 1'b1;
    while (!locked) @(negedge TX_CLK);
    // Bit 0 errors on about one cycle in four
    repeat (lockedCycles) begin
      txCtrl.errInject = ($urandom_range(3) == 0);
      if (txCtrl.errInject)
        tally++;
      @(negedge TX_CLK);
    end
    txCtrl.errInject = 1'b0;
    // Last error needs three edges to reach the accumulator
    repeat (3) @(negedge TX_CLK);
    readAndCheck(tally, sel.name());
    // Accumulator was cleared and nothing new was injected
    readAndCheck(0, "repeat read");
    if (dropClock)
      txClkStable = 1'b0;
    else
      txCtrl.enable = 1'b0;
    while (locked) @(negedge TX_CLK);
    repeat (4) @(negedge TX_CLK);
    txCtrl.enable = 1'b0;
    txClkStable = 1'b1;
  endtask

  //--------------------------------------------------
  // Main sequence
  //--------------------------------------------------
  initial begin
    void'($urandom(randSeed));
    txClkStable = 1'b1;
    txCtrl = '{enable: 1'b0, sel: selPrbs7, errInject: 1'b0};
    cntReq = 1'b0;
    @(posedge SYS_RESET_N);
    @(negedge TX_CLK);
    readAndCheck(0, "after reset");
    runPattern(selPrbs7, 1'b0);
    runPattern(selPrbs9, 1'b1);
    runPattern(selPrbs23, 1'b0);
    runPattern(selPrbs31, 1'b1);
    if (dut0.props0.failCount == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "concurrent assertion failed");
    end
  end

  // Stop at the first failed concurrent check
  always @(negedge TX_CLK) begin
    if (dut0.props0.failCount != 0) begin
      $display("Concurrent assertion failed at %0t ns", $time);
      $display("RESULT: FAIL");
      $fatal(1, "assertion failure");
    end
  end

  initial begin
    #(timeoutNs);
    $display("Watchdog expired after %0d ns, the run hung", timeoutNs);
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

endmodule

// File: tb.f
logic/prbsPkg.sv
logic/prbsGen.sv
logic/alignDetect.sv
logic/prbsChecker.sv
logic/errReadout.sv
logic/prbsLinkTop.sv
test/tbClock.sv
test/prbsLink_props.sv
test/prbsLinkTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the PRBS link testbench with Verilator and run it.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module prbsLinkTb -Mdir obj_dir -o prbsLinkSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed"
  exit "$status"
fi

# Higher error limit so the testbench reports the first assertion failure itself
./obj_dir/prbsLinkSim +verilator+error+limit+100
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed"
  exit "$status"
fi
echo "Simulation finished cleanly"
